// ==== hdl/conv_geom_pkg.sv ====
`default_nettype none

package conv_geom_pkg;

	// ==============================
	// Kernel geometry
	// ==============================

	// Side of the square kernel
	localparam int KDIM = 3;

	// Kernel positions per output
	localparam int TAPS = KDIM * KDIM;

	// Tap number, row-major from the top-left corner
	typedef logic [3:0] tap_idx_t;

	// ==============================
	// Input stream layout
	// ==============================
	localparam int PIX_PER_WORD = 4;

	// Words carrying the nine weights, last one only partly used
	localparam int WEIGHT_WORDS = 3;

endpackage

`default_nettype wire

// ==== hdl/conv_data_pkg.sv ====
`default_nettype none

package conv_data_pkg;

	// ==============================
	// Sample and coefficient types
	// ==============================
	typedef logic        [7:0]  pixel_t;
	typedef logic signed [7:0]  weight_t;

	// Nine 17-bit products fit in 21 bits
	typedef logic signed [20:0] acc_t;

	// Largest value of an output pixel
	localparam int PIX_MAX = 255;

	// Round half up, then drop the 7 fraction bits of the weights
	localparam int ROUND_BIAS  = 64;
	localparam int ROUND_SHIFT = 7;

	// ==============================
	// Input word
	// ==============================

	// Element 0 is the top byte in both views
	typedef union packed {
		pixel_t  [0:3] pix;
		weight_t [0:3] wgt;
	} in_word_u;

endpackage

`default_nettype wire

// ==== hdl/conv_input_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_input_loader
	import conv_data_pkg::*;
	import conv_geom_pkg::*;
#(
	parameter int IMG_DIM = 64
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_rst_n,
	input  wire logic                          i_in_valid,
	input  wire in_word_u                      i_in_data,
	output logic                               o_in_ready,
	output logic                               o_wr_en,
	output logic [WORD_AW-1:0]                 o_wr_addr,
	output pixel_t [0:PIX_PER_WORD-1]          o_wr_pixels,
	output logic [TAPS*$bits(weight_t)-1:0]    o_weights,
	output logic                               o_start
);

	localparam int IMG_WORDS = IMG_DIM * IMG_DIM / PIX_PER_WORD;
	localparam int WORD_AW   = $clog2(IMG_WORDS);
	localparam int WCNT_W    = $clog2(WEIGHT_WORDS);

	logic               ready_r;
	logic               done_r;
	logic               wgt_phase_r;
	logic [WORD_AW-1:0] word_cnt_r;
	logic [WCNT_W-1:0]  wgt_cnt_r;
	logic               start_r;
	weight_t            weights_r [TAPS];

	logic accept;
	logic last_img;
	logic last_wgt;

	assign accept   = i_in_valid & ready_r;
	assign last_img = accept & ~wgt_phase_r & (word_cnt_r == WORD_AW'(IMG_WORDS - 1));
	assign last_wgt = accept & wgt_phase_r & (wgt_cnt_r == WCNT_W'(WEIGHT_WORDS - 1));

	// Image words go straight to the frame buffer, decoded as pixels
	assign o_wr_en     = accept & ~wgt_phase_r;
	assign o_wr_addr   = word_cnt_r;
	assign o_wr_pixels = i_in_data.pix;

	// ==============================
	// Phase and handshake control
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_r     <= 1'b0;
			done_r      <= 1'b0;
			wgt_phase_r <= 1'b0;
			word_cnt_r  <= '0;
			wgt_cnt_r   <= '0;
			start_r     <= 1'b0;
		end else begin
			start_r <= last_wgt;
			if (last_wgt) begin
				ready_r <= 1'b0;
				done_r  <= 1'b1;
			end else if (!done_r) begin
				ready_r <= 1'b1;
			end
			if (o_wr_en) begin
				word_cnt_r <= word_cnt_r + 1'b1;
			end
			if (last_img) begin
				wgt_phase_r <= 1'b1;
			end
			if (accept && wgt_phase_r) begin
				wgt_cnt_r <= wgt_cnt_r + 1'b1;
			end
		end
	end

	// Weight words decoded as signed bytes, unused lanes dropped
	always_ff @(posedge i_clk) begin
		if (accept && wgt_phase_r) begin
			for (int k = 0; k < PIX_PER_WORD; k++) begin
				if (int'(wgt_cnt_r) * PIX_PER_WORD + k < TAPS) begin
					weights_r[int'(wgt_cnt_r) * PIX_PER_WORD + k] <= i_in_data.wgt[k];
				end
			end
		end
	end

	// Weight 0 sits in the lowest byte
	always_comb begin
		for (int t = 0; t < TAPS; t++) begin
			o_weights[t*$bits(weight_t) +: $bits(weight_t)] = weights_r[t];
		end
	end

	assign o_in_ready = ready_r;
	assign o_start    = start_r;

endmodule

`default_nettype wire

// ==== hdl/conv_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_frame_buffer
	import conv_data_pkg::*;
	import conv_geom_pkg::*;
#(
	parameter int IMG_DIM = 64
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_wr_en,
	input  wire logic [WORD_AW-1:0]            i_wr_addr,
	input  wire pixel_t [0:PIX_PER_WORD-1]     i_wr_pixels,
	input  wire logic                          i_rd_en,
	input  wire logic [PIX_AW-1:0]             i_rd_addr,
	output pixel_t                             o_rd_pixel
);

	localparam int PIX_AW  = 2 * $clog2(IMG_DIM);
	localparam int LANE_W  = $clog2(PIX_PER_WORD);
	localparam int WORD_AW = PIX_AW - LANE_W;

	pixel_t mem [IMG_DIM*IMG_DIM];
	pixel_t rd_r;

	// One word fills four neighbouring pixels of the same row
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			for (int k = 0; k < PIX_PER_WORD; k++) begin
				mem[{i_wr_addr, LANE_W'(k)}] <= i_wr_pixels[k];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rd_en) begin
			rd_r <= mem[i_rd_addr];
		end
	end

	assign o_rd_pixel = rd_r;

endmodule

`default_nettype wire

// ==== hdl/conv_window_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_window_scan
	import conv_geom_pkg::*;
#(
	parameter int IMG_DIM  = 64,
	parameter int STRIDE   = 1,
	parameter int DILATION = 1
) (
	input  wire logic               i_clk,
	input  wire logic               i_rst_n,
	input  wire logic               i_start,
	output logic                    o_rd_en,
	output logic [2*CW-1:0]         o_rd_addr,
	output logic                    o_tap_valid,
	output tap_idx_t                o_tap_idx,
	output logic                    o_tap_pad,
	output logic                    o_tap_last,
	output logic [2*OW-1:0]         o_out_addr,
	output logic                    o_scan_final
);

	localparam int CW      = $clog2(IMG_DIM);
	localparam int OUT_DIM = IMG_DIM / STRIDE;
	localparam int OW      = $clog2(OUT_DIM);
	localparam int SSH     = $clog2(STRIDE);
	localparam logic signed [CW+1:0] DIL_S = (CW+2)'(DILATION);

	logic          busy_r;
	tap_idx_t      tap_r;
	logic [1:0]    ky_r;
	logic [1:0]    kx_r;
	logic [OW-1:0] out_row_r;
	logic [OW-1:0] out_col_r;

	logic                 tap_last;
	logic                 last_out;
	logic [CW-1:0]        ctr_row;
	logic [CW-1:0]        ctr_col;
	logic signed [CW+1:0] row_off;
	logic signed [CW+1:0] col_off;
	logic signed [CW+1:0] src_row;
	logic signed [CW+1:0] src_col;
	logic                 pad;

	assign tap_last = (tap_r == tap_idx_t'(TAPS - 1));
	assign last_out = (out_row_r == OW'(OUT_DIM - 1)) && (out_col_r == OW'(OUT_DIM - 1));

	// ==============================
	// Source pixel of the current tap
	// ==============================
	assign ctr_row = CW'(out_row_r) << SSH;
	assign ctr_col = CW'(out_col_r) << SSH;
	assign row_off = (ky_r == 2'd0) ? -DIL_S : (ky_r == 2'd2) ? DIL_S : '0;
	assign col_off = (kx_r == 2'd0) ? -DIL_S : (kx_r == 2'd2) ? DIL_S : '0;
	assign src_row = $signed({2'b00, ctr_row}) + row_off;
	assign src_col = $signed({2'b00, ctr_col}) + col_off;

	// Sign bit set means left of the edge, bit CW set means past the far edge
	assign pad = src_row[CW+1] | src_row[CW] | src_col[CW+1] | src_col[CW];

	assign o_rd_en   = busy_r & ~pad;
	assign o_rd_addr = {src_row[CW-1:0], src_col[CW-1:0]};

	// ==============================
	// Output and tap counters
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy_r    <= 1'b0;
			tap_r     <= '0;
			ky_r      <= '0;
			kx_r      <= '0;
			out_row_r <= '0;
			out_col_r <= '0;
		end else if (i_start) begin
			busy_r    <= 1'b1;
			tap_r     <= '0;
			ky_r      <= '0;
			kx_r      <= '0;
			out_row_r <= '0;
			out_col_r <= '0;
		end else if (busy_r) begin
			if (tap_last) begin
				tap_r <= '0;
				ky_r  <= '0;
				kx_r  <= '0;
				if (out_col_r == OW'(OUT_DIM - 1)) begin
					out_col_r <= '0;
					out_row_r <= last_out ? '0 : out_row_r + 1'b1;
					busy_r    <= ~last_out;
				end else begin
					out_col_r <= out_col_r + 1'b1;
				end
			end else begin
				tap_r <= tap_r + 1'b1;
				if (kx_r == 2'(KDIM - 1)) begin
					kx_r <= '0;
					ky_r <= ky_r + 1'b1;
				end else begin
					kx_r <= kx_r + 1'b1;
				end
			end
		end
	end

	// Tags line up with the read data one cycle later
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_tap_valid  <= 1'b0;
			o_tap_idx    <= '0;
			o_tap_pad    <= 1'b0;
			o_tap_last   <= 1'b0;
			o_out_addr   <= '0;
			o_scan_final <= 1'b0;
		end else begin
			o_tap_valid  <= busy_r;
			o_tap_idx    <= tap_r;
			o_tap_pad    <= pad;
			o_tap_last   <= tap_last;
			o_out_addr   <= {out_row_r, out_col_r};
			o_scan_final <= busy_r & tap_last & last_out;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/conv_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mac
	import conv_data_pkg::*;
	import conv_geom_pkg::*;
#(
	parameter int IMG_DIM = 64,
	parameter int STRIDE  = 1
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_rst_n,
	input  wire logic                          i_tap_valid,
	input  wire tap_idx_t                      i_tap_idx,
	input  wire logic                          i_tap_pad,
	input  wire logic                          i_tap_last,
	input  wire logic [OUT_AW-1:0]             i_out_addr,
	input  wire logic                          i_final,
	input  wire pixel_t                        i_pixel,
	input  wire logic [TAPS*$bits(weight_t)-1:0] i_weights,
	output logic                               o_sum_valid,
	output acc_t                               o_sum,
	output logic [OUT_AW-1:0]                  o_out_addr,
	output logic                               o_final
);

	localparam int OUT_AW = 2 * $clog2(IMG_DIM / STRIDE);

	weight_t            tap_w;
	logic signed [16:0] prod;
	acc_t               acc_r;
	logic [OUT_AW-1:0]  addr_r;

	assign tap_w = i_weights[i_tap_idx*$bits(weight_t) +: $bits(weight_t)];

	// Pixel is unsigned, so widen with a zero before the signed multiply
	assign prod = i_tap_pad ? 17'sd0 : $signed({1'b0, i_pixel}) * tap_w;

	always_ff @(posedge i_clk) begin
		if (i_tap_valid) begin
			acc_r <= (i_tap_idx == '0) ? acc_t'(prod) : acc_r + acc_t'(prod);
			if (i_tap_last) begin
				addr_r <= i_out_addr;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sum_valid <= 1'b0;
			o_final     <= 1'b0;
		end else begin
			o_sum_valid <= i_tap_valid & i_tap_last;
			o_final     <= i_tap_valid & i_tap_last & i_final;
		end
	end

	assign o_sum      = acc_r;
	assign o_out_addr = addr_r;

endmodule

`default_nettype wire

// ==== hdl/conv_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_output_stage
	import conv_data_pkg::*;
#(
	parameter int IMG_DIM = 64,
	parameter int STRIDE  = 1
) (
	input  wire logic                i_clk,
	input  wire logic                i_rst_n,
	input  wire logic                i_sum_valid,
	input  wire acc_t                i_sum,
	input  wire logic [OUT_AW-1:0]   i_out_addr,
	input  wire logic                i_final,
	output logic                     o_out_valid,
	output pixel_t                   o_out_data,
	output logic [OUT_AW-1:0]        o_out_addr,
	output logic                     o_exe_finish
);

	localparam int OUT_AW = 2 * $clog2(IMG_DIM / STRIDE);

	acc_t   rounded;
	acc_t   shifted;
	pixel_t clamped;
	logic   last_r;
	logic   finish_r;

	// ==============================
	// Round, scale and saturate
	// ==============================
	assign rounded = i_sum + acc_t'(ROUND_BIAS);
	assign shifted = rounded >>> ROUND_SHIFT;
	assign clamped = (shifted < 0)                ? '0 :
	                 (shifted > acc_t'(PIX_MAX))  ? pixel_t'(PIX_MAX) :
	                 shifted[7:0];

	always_ff @(posedge i_clk) begin
		if (i_sum_valid) begin
			o_out_data <= clamped;
			o_out_addr <= i_out_addr;
		end
	end

	// Finish follows the last result by one cycle and holds until reset
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			last_r      <= 1'b0;
			finish_r    <= 1'b0;
		end else begin
			o_out_valid <= i_sum_valid;
			last_r      <= i_sum_valid & i_final;
			finish_r    <= finish_r | last_r;
		end
	end

	assign o_exe_finish = finish_r;

endmodule

`default_nettype wire

// ==== hdl/conv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_core
	import conv_data_pkg::*;
	import conv_geom_pkg::*;
#(
	parameter int IMG_DIM  = 64,
	parameter int STRIDE   = 1,
	parameter int DILATION = 1
) (
	input  wire logic                i_clk,
	input  wire logic                i_rst_n,
	input  wire logic                i_in_valid,
	input  wire logic [31:0]         i_in_data,
	output logic                     o_in_ready,
	output logic                     o_out_valid,
	output pixel_t                   o_out_data,
	output logic [OUT_AW-1:0]        o_out_addr,
	output logic                     o_exe_finish
);

	localparam int OUT_DIM = IMG_DIM / STRIDE;
	localparam int OUT_AW  = 2 * $clog2(OUT_DIM);
	localparam int PIX_AW  = 2 * $clog2(IMG_DIM);
	localparam int WORD_AW = PIX_AW - $clog2(PIX_PER_WORD);

	// ==============================
	// Interconnect
	// ==============================
	logic                           wr_en;
	logic [WORD_AW-1:0]             wr_addr;
	pixel_t [0:PIX_PER_WORD-1]      wr_pixels;
	logic [TAPS*$bits(weight_t)-1:0] weights;
	logic                           start;

	logic                           rd_en;
	logic [PIX_AW-1:0]              rd_addr;
	pixel_t                         rd_pixel;

	logic                           tap_valid;
	tap_idx_t                       tap_idx;
	logic                           tap_pad;
	logic                           tap_last;
	logic [OUT_AW-1:0]              scan_addr;
	logic                           scan_final;

	logic                           sum_valid;
	acc_t                           sum;
	logic [OUT_AW-1:0]              sum_addr;
	logic                           sum_final;

	conv_input_loader #(
		.IMG_DIM(IMG_DIM)
	) u_loader (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_in_valid (i_in_valid),
		.i_in_data  (i_in_data),
		.o_in_ready (o_in_ready),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.o_wr_pixels(wr_pixels),
		.o_weights  (weights),
		.o_start    (start)
	);

	conv_frame_buffer #(
		.IMG_DIM(IMG_DIM)
	) u_frame_buffer (
		.i_clk      (i_clk),
		.i_wr_en    (wr_en),
		.i_wr_addr  (wr_addr),
		.i_wr_pixels(wr_pixels),
		.i_rd_en    (rd_en),
		.i_rd_addr  (rd_addr),
		.o_rd_pixel (rd_pixel)
	);

	conv_window_scan #(
		.IMG_DIM (IMG_DIM),
		.STRIDE  (STRIDE),
		.DILATION(DILATION)
	) u_scan (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (start),
		.o_rd_en     (rd_en),
		.o_rd_addr   (rd_addr),
		.o_tap_valid (tap_valid),
		.o_tap_idx   (tap_idx),
		.o_tap_pad   (tap_pad),
		.o_tap_last  (tap_last),
		.o_out_addr  (scan_addr),
		.o_scan_final(scan_final)
	);

	conv_mac #(
		.IMG_DIM(IMG_DIM),
		.STRIDE (STRIDE)
	) u_mac (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_tap_valid(tap_valid),
		.i_tap_idx  (tap_idx),
		.i_tap_pad  (tap_pad),
		.i_tap_last (tap_last),
		.i_out_addr (scan_addr),
		.i_final    (scan_final),
		.i_pixel    (rd_pixel),
		.i_weights  (weights),
		.o_sum_valid(sum_valid),
		.o_sum      (sum),
		.o_out_addr (sum_addr),
		.o_final    (sum_final)
	);

	conv_output_stage #(
		.IMG_DIM(IMG_DIM),
		.STRIDE (STRIDE)
	) u_output (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_sum_valid (sum_valid),
		.i_sum       (sum),
		.i_out_addr  (sum_addr),
		.i_final     (sum_final),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_out_addr  (o_out_addr),
		.o_exe_finish(o_exe_finish)
	);

endmodule

`default_nettype wire

// ==== sim/conv_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_core_properties (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic o_in_ready,
	input wire logic o_out_valid,
	input wire logic o_exe_finish
);

	// ==============================
	// End of run
	// ==============================
	a_ready_after_finish: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_exe_finish |-> !o_in_ready)
		else $error("o_in_ready high while o_exe_finish is set");

	a_valid_after_finish: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_exe_finish |-> !o_out_valid)
		else $error("o_out_valid high while o_exe_finish is set");

	// ==============================
	// Result stream
	// ==============================

	// One cycle per result
	a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |=> !o_out_valid)
		else $error("o_out_valid high for two cycles in a row");

	// Results only start once the input side has closed
	a_ready_while_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid |-> !o_in_ready)
		else $error("o_out_valid high while o_in_ready is still high");

endmodule

bind conv_core conv_core_properties u_properties (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.o_in_ready  (o_in_ready),
	.o_out_valid (o_out_valid),
	.o_exe_finish(o_exe_finish)
);

`default_nettype wire

// ==== sim/tb_conv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_core
	import conv_data_pkg::*;
	import conv_geom_pkg::*;
#(
	parameter int IMG_DIM  = 16,
	parameter int STRIDE   = 2,
	parameter int DILATION = 2
);

	localparam int CLK_PERIOD   = 100;
	localparam int OUT_DIM      = IMG_DIM / STRIDE;
	localparam int OUT_AW       = 2 * $clog2(OUT_DIM);
	localparam int OUT_PIX      = OUT_DIM * OUT_DIM;
	localparam int NPIX         = IMG_DIM * IMG_DIM;
	localparam int IMG_WORDS    = NPIX / PIX_PER_WORD;
	localparam int WORD_LIMIT   = 64;
	localparam int FINISH_LIMIT = OUT_PIX * TAPS + 64;

	logic              i_clk;
	logic              i_rst_n;
	logic              i_in_valid;
	logic [31:0]       i_in_data;
	logic              o_in_ready;
	logic              o_out_valid;
	logic [7:0]        o_out_data;
	logic [OUT_AW-1:0] o_out_addr;
	logic              o_exe_finish;

	// Stored copy of what was sent, used by the reference model
	logic        [7:0] img [NPIX];
	logic signed [7:0] wgt [TAPS];

	logic [31:0] rng_state;
	int          mismatches;
	int          other_errs;
	int          timeouts;

	// Owned by the comparison process
	int   res_cnt;
	int   next_addr;
	int   sat_hi;
	int   sat_lo;
	logic finish_seen;
	logic prev_valid;

	conv_core #(
		.IMG_DIM (IMG_DIM),
		.STRIDE  (STRIDE),
		.DILATION(DILATION)
	) uut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_out_addr  (o_out_addr),
		.o_exe_finish(o_exe_finish)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// ==============================
	// Random numbers and reference
	// ==============================
	function automatic int next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return int'(rng_state[31:16]);
	endfunction

	// One output pixel, zero padding outside the image
	function automatic logic [7:0] conv_ref(input int row, input int col);
		int acc;
		int r;
		int c;
		acc = 0;
		for (int ky = 0; ky < 3; ky++) begin
			for (int kx = 0; kx < 3; kx++) begin
				r = row * STRIDE + (ky - 1) * DILATION;
				c = col * STRIDE + (kx - 1) * DILATION;
				if (r >= 0 && r < IMG_DIM && c >= 0 && c < IMG_DIM) begin
					acc += int'(img[r * IMG_DIM + c]) * int'(wgt[ky * 3 + kx]);
				end
			end
		end
		acc = (acc + ROUND_BIAS) >>> ROUND_SHIFT;
		if (acc < 0) begin
			return 8'd0;
		end else if (acc > 255) begin
			return 8'd255;
		end
		return 8'(acc);
	endfunction

	// ==============================
	// Comparison process
	// ==============================
	task automatic check_result();
		int         row;
		int         col;
		logic [7:0] exp_pix;
		row = int'(o_out_addr) / OUT_DIM;
		col = int'(o_out_addr) % OUT_DIM;
		if (o_exe_finish) begin
			other_errs++;
			$display("A result arrived after o_exe_finish was set");
		end
		if (res_cnt >= OUT_PIX) begin
			other_errs++;
			$display("More results arrived than there are output positions");
		end
		if (o_out_addr !== OUT_AW'(next_addr)) begin
			mismatches++;
			$display("Mismatch o_out_addr: got %0h expected %0h", o_out_addr, next_addr);
		end
		exp_pix = conv_ref(row, col);
		if (o_out_data !== exp_pix) begin
			mismatches++;
			$display("Mismatch o_out_data at addr %0h: got %02h expected %02h",
				o_out_addr, o_out_data, exp_pix);
		end
		if (o_out_data == 8'hff) begin
			sat_hi++;
		end
		if (o_out_data == 8'h00) begin
			sat_lo++;
		end
		res_cnt++;
		// Resync so that one wrong address does not flag every later one
		next_addr = int'(o_out_addr) + 1;
	endtask

	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			res_cnt     = 0;
			next_addr   = 0;
			sat_hi      = 0;
			sat_lo      = 0;
			finish_seen = 1'b0;
			prev_valid  = 1'b0;
		end else begin
			if (o_out_valid) begin
				check_result();
			end
			if (o_exe_finish && !finish_seen) begin
				finish_seen = 1'b1;
				if (res_cnt != OUT_PIX) begin
					other_errs++;
					$display("o_exe_finish rose after %0d of %0d results", res_cnt, OUT_PIX);
				end
				if (!prev_valid) begin
					other_errs++;
					$display("o_exe_finish did not rise in the cycle after the last result");
				end
			end
			prev_valid = o_out_valid;
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic check_ready_low(input string where);
		if (o_in_ready !== 1'b0) begin
			mismatches++;
			$display("Mismatch o_in_ready %s: got %h expected 0", where, o_in_ready);
		end
	endtask

	task automatic apply_reset();
		i_rst_n    = 1'b0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		repeat (2) @(posedge i_clk);
		#1;
		if (o_out_valid !== 1'b0 || o_exe_finish !== 1'b0) begin
			mismatches++;
			$display("Mismatch o_out_valid/o_exe_finish in reset: got %h/%h expected 0/0",
				o_out_valid, o_exe_finish);
		end
		i_rst_n = 1'b1;
		check_ready_low("right after reset");
		@(posedge i_clk);
		#1;
		if (o_in_ready !== 1'b1) begin
			mismatches++;
			$display("Mismatch o_in_ready one edge after reset: got %h expected 1", o_in_ready);
		end
	endtask

	// Random idle cycles between words
	task automatic idle_gap();
		int n;
		n = (next_rand() % 4 == 0) ? 1 + next_rand() % 3 : 0;
		i_in_valid = 1'b0;
		repeat (n) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic send_word(input logic [31:0] data);
		int waited;
		waited     = 0;
		i_in_valid = 1'b1;
		i_in_data  = data;
		while (!o_in_ready && waited < WORD_LIMIT) begin
			@(posedge i_clk);
			#1;
			waited++;
		end
		if (!o_in_ready) begin
			timeouts++;
			$display("Timeout: o_in_ready stayed low while an input word was offered");
		end
		@(posedge i_clk);
		#1;
		i_in_valid = 1'b0;
	endtask

	// Words offered while ready is low must be ignored
	task automatic offer_extra_words(input int count);
		for (int k = 0; k < count; k++) begin
			i_in_valid = 1'b1;
			i_in_data  = {16'(next_rand()), 16'(next_rand())};
			check_ready_low("while extra words are offered");
			@(posedge i_clk);
			#1;
		end
		i_in_valid = 1'b0;
	endtask

	// Mode 0 random, 1 bright with large positive weights, 2 large negative
	task automatic fill_case(input int mode);
		for (int i = 0; i < NPIX; i++) begin
			img[i] = (mode == 0) ? 8'(next_rand()) : 8'(192 + next_rand() % 64);
		end
		for (int t = 0; t < TAPS; t++) begin
			case (mode)
				0:       wgt[t] = 8'(next_rand() % 64 - 32);
				1:       wgt[t] = 8'(100 + next_rand() % 28);
				default: wgt[t] = 8'(-100 - next_rand() % 28);
			endcase
		end
	endtask

	task automatic run_case(input int mode);
		int waited;
		fill_case(mode);
		apply_reset();
		for (int k = 0; k < IMG_WORDS; k++) begin
			idle_gap();
			send_word({img[4*k], img[4*k+1], img[4*k+2], img[4*k+3]});
		end
		idle_gap();
		send_word({wgt[0], wgt[1], wgt[2], wgt[3]});
		idle_gap();
		send_word({wgt[4], wgt[5], wgt[6], wgt[7]});
		idle_gap();
		// Lower three bytes of the last weight word carry junk
		send_word({wgt[8], 24'(next_rand() * 251)});
		check_ready_low("after the last weight word");
		offer_extra_words(16);
		waited = 0;
		while (!o_exe_finish && waited < FINISH_LIMIT) begin
			check_ready_low("while results stream out");
			@(posedge i_clk);
			#1;
			waited++;
		end
		if (!o_exe_finish) begin
			timeouts++;
			$display("Timeout: o_exe_finish never rose in case %0d", mode);
		end
		repeat (4) begin
			@(posedge i_clk);
			#1;
		end
		check_ready_low("after finish");
		if (res_cnt != OUT_PIX) begin
			other_errs++;
			$display("Case %0d produced %0d results instead of %0d", mode, res_cnt, OUT_PIX);
		end
		if (mode == 1 && sat_hi == 0) begin
			other_errs++;
			$display("No result clamped to 255 with a bright image and positive weights");
		end
		if (mode == 2 && sat_lo == 0) begin
			other_errs++;
			$display("No result clamped to 0 with negative weights");
		end
	endtask

	initial begin
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		rng_state  = 32'd65594;
		mismatches = 0;
		other_errs = 0;
		timeouts   = 0;
		for (int mode = 0; mode < 3; mode++) begin
			run_case(mode);
		end
		$display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
			mismatches, other_errs, timeouts);
		if (mismatches == 0 && other_errs == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/conv_geom_pkg.sv
hdl/conv_data_pkg.sv
hdl/conv_input_loader.sv
hdl/conv_frame_buffer.sv
hdl/conv_window_scan.sv
hdl/conv_mac.sv
hdl/conv_output_stage.sv
hdl/conv_core.sv
sim/conv_core_properties.sv
sim/tb_conv_core.sv

// ==== Makefile ====
# Verilator flow for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
IMG_DIM   ?= 16
STRIDE    ?= 2
DILATION  ?= 2
VFLAGS    ?= --timing --assert

PARAMS = -GIMG_DIM=$(IMG_DIM) -GSTRIDE=$(STRIDE) -GDILATION=$(DILATION)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP) $(PARAMS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) $(PARAMS) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
